/* logic/mapperPkg.sv */
/*
 * Shared constants for the pixel colour stage: widths, state codes,
 * platform geometry, LFSR seeds and the palette.
 */
package mapperPkg;

    localparam int CoordWidth   = 10;
    localparam int PlatWidth    = 9;
    localparam int NumPlatforms = 16;
    localparam int NumCannons   = 3;

    // game state codes
    localparam logic [2:0] StateMenu    = 3'b000;
    localparam logic [2:0] StateLoading = 3'b001;
    localparam logic [2:0] StateGame    = 3'b010;
    localparam logic [2:0] StatePause   = 3'b011;
    localparam logic [2:0] StateRefresh = 3'b100;
    localparam logic [2:0] StateInit    = 3'b101;

    // ------------------------------------------------------------
    // platform geometry
    // ------------------------------------------------------------
    // index 0 is the top row
    localparam logic [NumPlatforms-1:0][PlatWidth-1:0] PlatRowY = {
        9'd475, 9'd450, 9'd420, 9'd390, 9'd360, 9'd330, 9'd300, 9'd270,
        9'd240, 9'd210, 9'd180, 9'd150, 9'd120, 9'd90, 9'd60, 9'd30
    };

    localparam logic [NumPlatforms-1:0][PlatWidth-1:0] LfsrSeeds = {
        9'h037, 9'h14E, 9'h091, 9'h1D6, 9'h068, 9'h12B, 9'h0E4, 9'h19F,
        9'h05A, 9'h171, 9'h0C2, 9'h1E9, 9'h03D, 9'h15C, 9'h0A7, 9'h1B3
    };

    localparam logic [PlatWidth-1:0] PlatXOffset = 9'd100;
    localparam logic [PlatWidth-1:0] OddBandLow  = 9'd201;
    localparam logic [PlatWidth-1:0] OddBandHigh = 9'd400;

    // half-width per difficulty, hard and the spare code share a size
    localparam logic [3:0][CoordWidth-1:0] PlatHalfX = {10'd8, 10'd8, 10'd16, 10'd32};
    localparam logic [CoordWidth-1:0]      PlatHalfY = 10'd4;

    // easy, medium, hard
    localparam logic [2:0][CoordWidth-1:0] MenuButtonX = {10'd430, 10'd330, 10'd230};
    localparam logic [CoordWidth-1:0]      MenuButtonY = 10'd200;

    localparam logic [5:0] CountdownBase = 6'd37;

    // ------------------------------------------------------------
    // palette, 24-bit RGB
    // ------------------------------------------------------------
    localparam logic [23:0] ColDoodle     = 24'hA5A525;
    localparam logic [23:0] ColEasy       = 24'h0000FF;
    localparam logic [23:0] ColMedium     = 24'h00FF00;
    localparam logic [23:0] ColHard       = 24'hFF0000;
    localparam logic [23:0] ColPlatform   = 24'h66DD11;
    localparam logic [23:0] ColBackground = 24'hEDE2D4;
    localparam logic [NumCannons-1:0][23:0] ColCannon = {
        24'hFF6666, 24'hFF3333, 24'hFF0000
    };

endpackage

/* logic/platformLfsr.sv */
/*
 * 9-bit Fibonacci LFSR, taps at bits 9 and 5, free running
 * from a per-instance seed.
 */
module platformLfsr #(
    parameter logic [mapperPkg::PlatWidth-1:0] Seed = 9'h001
)
(
    input  logic                              Clk,
    input  logic                              loadplat,
    output logic [mapperPkg::PlatWidth-1:0]   value
);

    logic feedback;

    // taps 9 and 5 in one-based numbering
    assign feedback = value[8] ^ value[4];

    always_ff @(posedge Clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            value <= Seed;
        end
        else
        begin
            value <= {value[7:0], feedback};
        end
    end

endmodule

/* logic/platformPlacer.sv */
/*
 * Platform placer: random X capture from the LFSR bank, layout load
 * and per-frame upward scrolling of all platform rows.
 */
module platformPlacer (
    input  logic                                                       Clk,
    input  logic                                                       loadplat,
    input  logic                                                       frameTick,
    input  logic [2:0]                                                 gameState,
    input  logic [8:0]                                                 scrollY,
    output logic [mapperPkg::NumPlatforms-1:0][mapperPkg::PlatWidth-1:0] platX,
    output logic [mapperPkg::NumPlatforms-1:0][mapperPkg::PlatWidth-1:0] platY
);

    import mapperPkg::*;

    logic [PlatWidth-1:0] rawX   [NumPlatforms];
    logic [PlatWidth-1:0] readyX [NumPlatforms];

    // load-time shift, values past the odd band stay put
    function automatic logic [PlatWidth-1:0] placeX(input logic [PlatWidth-1:0] ready);
        if (ready <= OddBandHigh)
            return ready + PlatXOffset;
        return ready;
    endfunction

    // ------------------------------------------------------------
    // random sources
    // ------------------------------------------------------------
    for (genvar i = 0; i < NumPlatforms; i++)
    begin : gLfsr
        platformLfsr #(
            .Seed(LfsrSeeds[i])
        ) uLfsr (
            .Clk(Clk),
            .loadplat(loadplat),
            .value(rawX[i])
        );
    end

    // even slots take any nonzero low byte, odd slots only the band
    always_ff @(posedge Clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            for (int i = 0; i < NumPlatforms; i++)
            begin
                readyX[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < NumPlatforms; i++)
            begin
                if (i % 2 == 0)
                begin
                    if (rawX[i] != '0)
                        readyX[i] <= {1'b0, rawX[i][7:0]};
                end
                else if (rawX[i] >= OddBandLow && rawX[i] <= OddBandHigh)
                begin
                    readyX[i] <= rawX[i];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // layout load, menu clear and scroll, once per frame
    // ------------------------------------------------------------
    always_ff @(posedge Clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            platX <= '0;
            platY <= '0;
        end
        else if (frameTick)
        begin
            if (gameState == StateLoading)
            begin
                platY <= PlatRowY;
                for (int i = 0; i < NumPlatforms; i++)
                begin
                    platX[i] <= placeX(readyX[i]);
                end
            end
            else if (gameState == StateMenu)
            begin
                platY <= '0;
            end
            else
            begin
                // 9-bit wrap gives the modulo 512
                for (int i = 0; i < NumPlatforms; i++)
                begin
                    platY[i] <= platY[i] - scrollY;
                end
            end
        end
    end

    loadSetsRows: assert property (@(posedge Clk) disable iff (loadplat)
        (frameTick && gameState == StateLoading) |=> (platY == PlatRowY));

endmodule

/* logic/refreshTimer.sv */
/*
 * Refresh timer: counts frame ticks in the refresh state and raises
 * trigger once the airtime-dependent countdown has run out.
 */
module refreshTimer (
    input  logic       Clk,
    input  logic       loadplat,
    input  logic       frameTick,
    input  logic [2:0] gameState,
    input  logic [5:0] airtime,
    output logic       trigger
);

    import mapperPkg::*;

    logic       inRefresh;
    logic       inPause;
    logic [5:0] count;

    // state decode
    assign inRefresh = (gameState == StateRefresh);
    assign inPause   = (gameState == StatePause);

    // ------------------------------------------------------------
    // countdown and trigger, advanced by frame ticks only
    // ------------------------------------------------------------
    always_ff @(posedge Clk or posedge loadplat)
    begin
        if (loadplat)
        begin
            count   <= CountdownBase;
            trigger <= 1'b0;
        end
        else if (frameTick)
        begin
            if (inRefresh)
            begin
                // trigger follows the count seen before this tick
                trigger <= (count == '0);
                if (count != '0)
                    count <= count - 6'd1;
            end
            else if (!inPause)
            begin
                count   <= CountdownBase - airtime;
                trigger <= 1'b0;
            end
        end
    end

    // pause holds both count and trigger

    triggerOnlyInRefresh: assert property (@(posedge Clk) disable iff (loadplat)
        $rose(trigger) |-> $past(frameTick && gameState == StateRefresh));

endmodule

/* logic/spriteLayer.sv */
/*
 * Sprite layer: box hit tests for doodle, menu buttons, platforms and
 * cannons, then the priority pick, registered one clock later.
 */
module spriteLayer (
    input  logic                                                         Clk,
    input  logic                                                         loadplat,
    input  logic [2:0]                                                   gameState,
    input  logic [1:0]                                                   difficulty,
    input  logic [mapperPkg::CoordWidth-1:0]                             drawX,
    input  logic [mapperPkg::CoordWidth-1:0]                             drawY,
    input  logic [mapperPkg::CoordWidth-1:0]                             doodleX,
    input  logic [mapperPkg::CoordWidth-1:0]                             doodleY,
    input  logic [mapperPkg::CoordWidth-1:0]                             doodleSize,
    input  logic [mapperPkg::NumCannons-1:0][mapperPkg::CoordWidth-1:0]  cannonX,
    input  logic [mapperPkg::NumCannons-1:0][mapperPkg::CoordWidth-1:0]  cannonY,
    input  logic [mapperPkg::CoordWidth-1:0]                             cannonSize,
    input  logic [mapperPkg::NumPlatforms-1:0][mapperPkg::PlatWidth-1:0] platX,
    input  logic [mapperPkg::NumPlatforms-1:0][mapperPkg::PlatWidth-1:0] platY,
    output logic [7:0]                                                   red,
    output logic [7:0]                                                   green,
    output logic [7:0]                                                   blue
);

    import mapperPkg::*;

    logic [CoordWidth-1:0] halfX;
    logic                  inMenu;
    logic                  doodleHit;
    logic                  platHit;
    logic [2:0]            buttonHit;
    logic [NumCannons-1:0] cannonHit;
    logic [23:0]           pixelColour;

    // box test with 10-bit wrapping edges
    function automatic logic inBox(
        input logic [CoordWidth-1:0] px,
        input logic [CoordWidth-1:0] py,
        input logic [CoordWidth-1:0] cx,
        input logic [CoordWidth-1:0] cy,
        input logic [CoordWidth-1:0] hx,
        input logic [CoordWidth-1:0] hy
    );
        logic [CoordWidth-1:0] left;
        logic [CoordWidth-1:0] right;
        logic [CoordWidth-1:0] top;
        logic [CoordWidth-1:0] bottom;
        left   = cx - hx;
        right  = cx + hx;
        top    = cy - hy;
        bottom = cy + hy;
        return (px >= left) && (px <= right) && (py >= top) && (py <= bottom);
    endfunction

    assign halfX  = PlatHalfX[difficulty];
    assign inMenu = (gameState == StateMenu);

    // ------------------------------------------------------------
    // hit tests
    // ------------------------------------------------------------
    assign doodleHit = inBox(drawX, drawY, doodleX, doodleY, doodleSize, doodleSize);

    always_comb
    begin
        platHit = 1'b0;
        for (int i = 0; i < NumPlatforms; i++)
        begin
            if (inBox(drawX, drawY, {1'b0, platX[i]}, {1'b0, platY[i]}, halfX, PlatHalfY))
                platHit = 1'b1;
        end
        for (int b = 0; b < 3; b++)
        begin
            buttonHit[b] = inMenu && inBox(drawX, drawY, MenuButtonX[b], MenuButtonY,
                                           halfX, PlatHalfY);
        end
        for (int c = 0; c < NumCannons; c++)
        begin
            cannonHit[c] = inBox(drawX, drawY, cannonX[c], cannonY[c], cannonSize, cannonSize);
        end
    end

    // ------------------------------------------------------------
    // priority, doodle on top
    // ------------------------------------------------------------
    always_comb
    begin
        if (doodleHit)
            pixelColour = ColDoodle;
        else if (buttonHit[0])
            pixelColour = ColEasy;
        else if (buttonHit[1])
            pixelColour = ColMedium;
        else if (buttonHit[2])
            pixelColour = ColHard;
        else if (platHit)
            pixelColour = ColPlatform;
        else if (cannonHit[0])
            pixelColour = ColCannon[0];
        else if (cannonHit[1])
            pixelColour = ColCannon[1];
        else if (cannonHit[2])
            pixelColour = ColCannon[2];
        else
            pixelColour = ColBackground;
    end

    always_ff @(posedge Clk or posedge loadplat)
    begin
        if (loadplat)
            {red, green, blue} <= '0;
        else
            {red, green, blue} <= pixelColour;
    end

    colourKnown: assert property (@(posedge Clk) disable iff (loadplat)
        !$isunknown({red, green, blue}));

endmodule

/* logic/colorMapper.sv */
/*
 * Colour mapper top: platform placer, refresh timer and sprite layer.
 */
module colorMapper (
    input  logic                                                         Clk,
    input  logic                                                         loadplat,
    input  logic                                                         frameTick,
    input  logic [2:0]                                                   gameState,
    input  logic [1:0]                                                   difficulty,
    input  logic [8:0]                                                   scrollY,
    input  logic [5:0]                                                   airtime,
    input  logic [mapperPkg::CoordWidth-1:0]                             doodleX,
    input  logic [mapperPkg::CoordWidth-1:0]                             doodleY,
    input  logic [mapperPkg::CoordWidth-1:0]                             doodleSize,
    input  logic [mapperPkg::NumCannons-1:0][mapperPkg::CoordWidth-1:0]  cannonX,
    input  logic [mapperPkg::NumCannons-1:0][mapperPkg::CoordWidth-1:0]  cannonY,
    input  logic [mapperPkg::CoordWidth-1:0]                             cannonSize,
    input  logic [mapperPkg::CoordWidth-1:0]                             drawX,
    input  logic [mapperPkg::CoordWidth-1:0]                             drawY,
    output logic [7:0]                                                   red,
    output logic [7:0]                                                   green,
    output logic [7:0]                                                   blue,
    output logic                                                         trigger,
    output logic [mapperPkg::NumPlatforms-1:0][mapperPkg::PlatWidth-1:0] platX,
    output logic [mapperPkg::NumPlatforms-1:0][mapperPkg::PlatWidth-1:0] platY
);

    platformPlacer uPlacer (
        .Clk(Clk),
        .loadplat(loadplat),
        .frameTick(frameTick),
        .gameState(gameState),
        .scrollY(scrollY),
        .platX(platX),
        .platY(platY)
    );

    refreshTimer uTimer (
        .Clk(Clk),
        .loadplat(loadplat),
        .frameTick(frameTick),
        .gameState(gameState),
        .airtime(airtime),
        .trigger(trigger)
    );

    // platform positions also feed the pixel tests
    spriteLayer uSprites (
        .Clk(Clk),
        .loadplat(loadplat),
        .gameState(gameState),
        .difficulty(difficulty),
        .drawX(drawX),
        .drawY(drawY),
        .doodleX(doodleX),
        .doodleY(doodleY),
        .doodleSize(doodleSize),
        .cannonX(cannonX),
        .cannonY(cannonY),
        .cannonSize(cannonSize),
        .platX(platX),
        .platY(platY),
        .red(red),
        .green(green),
        .blue(blue)
    );

endmodule

/* tb/mapperChecks.svh */
/*
 * Testbench checks: mismatch report and reference models for the
 * platform row table and the pixel colour priority.
 */
`ifndef MAPPER_CHECKS_SVH
`define MAPPER_CHECKS_SVH

task automatic reportMismatch(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    valueErrors++;
    $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
endtask

// rows 30 apart from the top, last row pulled up to 475
function automatic logic [8:0] rowY(input int i);
    return (i == 15) ? 9'd475 : 9'(30 * (i + 1));
endfunction

// box edges wrap at 10 bits
function automatic logic boxHit(input logic [9:0] px, input logic [9:0] py,
                                input logic [9:0] cx, input logic [9:0] cy,
                                input logic [9:0] hx, input logic [9:0] hy);
    return (px >= 10'(cx - hx)) && (px <= 10'(cx + hx)) &&
           (py >= 10'(cy - hy)) && (py <= 10'(cy + hy));
endfunction

function automatic logic [23:0] refColour(input logic [9:0] px, input logic [9:0] py);
    logic [9:0] hx;
    logic       onPlatform;
    hx = (difficulty == 2'd0) ? 10'd32 : (difficulty == 2'd1) ? 10'd16 : 10'd8;
    onPlatform = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
        if (boxHit(px, py, {1'b0, modelX[i]}, {1'b0, modelY[i]}, hx, 10'd4))
            onPlatform = 1'b1;
    end
    if (boxHit(px, py, doodleX, doodleY, doodleSize, doodleSize))
        return 24'hA5A525;
    // easy, medium, hard walk from blue to green to red
    for (int b = 0; b < 3; b++)
    begin
        if (gameState == 3'd0 && boxHit(px, py, 10'(230 + 100 * b), 10'd200, hx, 10'd4))
            return 24'h0000FF << (8 * b);
    end
    if (onPlatform)
        return 24'h66DD11;
    for (int c = 0; c < 3; c++)
    begin
        if (boxHit(px, py, cannonX[c], cannonY[c], cannonSize, cannonSize))
            return 24'(24'hFF0000 + 24'h003333 * c);
    end
    return 24'hEDE2D4;
endfunction

`endif

/* tb/colorMapperTb.sv */
/*
 * Testbench for the colour mapper. Replays the command file against
 * the DUT, with a watchdog and one closing report.
 */
module colorMapperTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    RandSeed  = 78410;
    localparam string TestsPath = "tb/mapperTests.txt";

    logic             Clk;
    logic             loadplat;
    logic             frameTick;
    logic [2:0]       gameState;
    logic [1:0]       difficulty;
    logic [8:0]       scrollY;
    logic [5:0]       airtime;
    logic [9:0]       doodleX;
    logic [9:0]       doodleY;
    logic [9:0]       doodleSize;
    logic [2:0][9:0]  cannonX;
    logic [2:0][9:0]  cannonY;
    logic [9:0]       cannonSize;
    logic [9:0]       drawX;
    logic [9:0]       drawY;
    logic [7:0]       red;
    logic [7:0]       green;
    logic [7:0]       blue;
    logic             trigger;
    logic [15:0][8:0] platX;
    logic [15:0][8:0] platY;

    // expected platform positions after each frame tick
    logic [8:0] modelX [16];
    logic [8:0] modelY [16];
    int         valueErrors;
    int         otherErrors;
    int         lineCount;

    `include "mapperChecks.svh"

    colorMapper UUT (.*);

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // the line count is final once reset is released
    initial
    begin
        @(negedge loadplat);
        #(lineCount * 200 + 1000);
        $display("watchdog expired, the %0d test lines did not finish in time", lineCount);
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // frame ticks with the Y model stepped alongside
    // ------------------------------------------------------------
    task automatic frameTicks(input int count);
        for (int k = 0; k < count; k++)
        begin
            frameTick = 1'b1;
            @(negedge Clk);
            frameTick = 1'b0;
            for (int i = 0; i < 16; i++)
            begin
                if (gameState == 3'd1)
                begin
                    modelY[i] = rowY(i);
                    modelX[i] = platX[i];
                end
                else if (gameState == 3'd0)
                    modelY[i] = 9'd0;
                else
                    modelY[i] = modelY[i] - scrollY;
            end
        end
    endtask

    // colour shows up one clock after the coordinates
    task automatic checkPixel(input logic [9:0] x, input logic [9:0] y,
                              input logic [23:0] expected);
        drawX = x;
        drawY = y;
        @(negedge Clk);
        if ({red, green, blue} !== expected)
            reportMismatch($sformatf("rgb at %0d,%0d", x, y), 32'({red, green, blue}),
                           32'(expected));
    endtask

    task automatic applySetting(input string field, input int a, input int b, input int c);
        case (field)
            "state":  gameState  = 3'(a);
            "diff":   difficulty = 2'(a);
            "scroll": scrollY    = 9'(a);
            "air":    airtime    = 6'(a);
            "csize":  cannonSize = 10'(a);
            "doodle":
            begin
                doodleX    = 10'(a);
                doodleY    = 10'(b);
                doodleSize = 10'(c);
            end
            "cannon":
            begin
                cannonX[a] = 10'(b);
                cannonY[a] = 10'(c);
            end
            default:
            begin
                $display("unknown setting %s in the test file", field);
                otherErrors++;
            end
        endcase
    endtask

    task automatic runCheck(input string what, input int value);
        case (what)
            "reset":
            begin
                if (trigger !== 1'b0)
                    reportMismatch("trigger", 32'(trigger), 32'd0);
                for (int i = 0; i < 16; i++)
                begin
                    if (platX[i] !== 9'd0)
                        reportMismatch($sformatf("platX[%0d]", i), 32'(platX[i]), 32'd0);
                    if (platY[i] !== 9'd0)
                        reportMismatch($sformatf("platY[%0d]", i), 32'(platY[i]), 32'd0);
                end
            end
            "platy":
            begin
                for (int i = 0; i < 16; i++)
                begin
                    if (platY[i] !== modelY[i])
                        reportMismatch($sformatf("platY[%0d]", i), 32'(platY[i]),
                                       32'(modelY[i]));
                end
            end
            "platx":
            begin
                // a slot that never captured a value loads as the bare offset of 100
                for (int i = 0; i < 16; i++)
                begin
                    if ((i % 2 == 0 && (platX[i] < 9'd100 || platX[i] > 9'd355)) ||
                        (i % 2 == 1 && platX[i] != 9'd100 &&
                         (platX[i] < 9'd301 || platX[i] > 9'd500)))
                    begin
                        $display("platX[%0d] = %0d lies outside its placement band at %0d ns",
                                 i, platX[i], $time);
                        otherErrors++;
                    end
                end
            end
            "trigger":
            begin
                if (trigger !== 1'(value))
                    reportMismatch("trigger", 32'(trigger), 32'(value));
            end
            default:
            begin
                $display("unknown check %s in the test file", what);
                otherErrors++;
            end
        endcase
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial
    begin
        int          fd;
        int          a;
        int          b;
        int          c;
        string       line;
        string       cmd;
        string       field;
        logic [23:0] rgb;

        void'($urandom(RandSeed));
        valueErrors = 0;
        otherErrors = 0;
        lineCount   = 0;
        loadplat    = 1'b1;
        frameTick   = 1'b0;
        gameState   = 3'd0;
        difficulty  = 2'd0;
        scrollY     = 9'd0;
        airtime     = 6'd0;
        doodleX     = 10'd800;
        doodleY     = 10'd800;
        doodleSize  = 10'd5;
        cannonX     = {10'd780, 10'd740, 10'd700};
        cannonY     = {10'd700, 10'd700, 10'd700};
        cannonSize  = 10'd6;
        drawX       = 10'd0;
        drawY       = 10'd0;
        for (int i = 0; i < 16; i++)
        begin
            modelX[i] = 9'd0;
            modelY[i] = 9'd0;
        end

        // first pass sizes the watchdog
        fd = $fopen(TestsPath, "r");
        if (fd != 0)
        begin
            while ($fgets(line, fd) > 0)
                lineCount++;
            $fclose(fd);
            fd = $fopen(TestsPath, "r");
        end
        else
        begin
            $display("cannot open the test file %s", TestsPath);
            otherErrors++;
        end

        repeat (4) @(negedge Clk);
        loadplat = 1'b0;

        while (fd != 0 && $fgets(line, fd) > 0)
        begin
            if ($sscanf(line, "%s", cmd) != 1 || cmd[0] == "#")
                continue;
            if (cmd == "set")
            begin
                void'($sscanf(line, "%s %s %d %d %d", cmd, field, a, b, c));
                applySetting(field, a, b, c);
            end
            else if (cmd == "tick")
            begin
                void'($sscanf(line, "%s %d", cmd, a));
                frameTicks(a);
            end
            else if (cmd == "pixel")
            begin
                void'($sscanf(line, "%s %d %d %h", cmd, a, b, rgb));
                checkPixel(10'(a), 10'(b), rgb);
            end
            else if (cmd == "plat")
            begin
                void'($sscanf(line, "%s %d %d %d %h", cmd, a, b, c, rgb));
                checkPixel(10'(int'(modelX[a]) + b), 10'(int'(modelY[a]) + c), rgb);
            end
            else if (cmd == "random")
            begin
                void'($sscanf(line, "%s %d", cmd, a));
                for (int k = 0; k < a; k++)
                begin
                    b = int'($urandom % 640);
                    c = int'($urandom % 512);
                    checkPixel(10'(b), 10'(c), refColour(10'(b), 10'(c)));
                end
            end
            else if (cmd == "check")
            begin
                void'($sscanf(line, "%s %s %d", cmd, field, a));
                runCheck(field, a);
            end
            else
            begin
                $display("unknown command %s in the test file", cmd);
                otherErrors++;
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* tb/mapperTests.txt */
# commands: set <field> <values> | tick <count> | pixel <x> <y> <rgb> | random <count>
# plat <index> <dx> <dy> <rgb> | check reset | check platy | check platx | check trigger <v>
check reset
pixel 230 200 0000FF
pixel 330 200 00FF00
pixel 430 200 FF0000
pixel 250 200 0000FF
set diff 1
pixel 250 200 EDE2D4
set diff 2
pixel 350 200 EDE2D4
set diff 0
set doodle 230 200 3
pixel 233 203 A5A525
set doodle 800 800 5
set state 1
tick 1
check platy
check platx
set state 2
plat 3 0 0 66DD11
plat 3 33 0 EDE2D4
plat 3 0 5 EDE2D4
set cannon 0 600 100
set cannon 1 606 100
set cannon 2 612 100
pixel 603 100 FF0000
pixel 608 100 FF3333
pixel 616 100 FF6666
random 30
set csize 250
set cannon 2 300 300
plat 5 0 0 66DD11
plat 5 0 6 FF6666
set scroll 7
tick 3
check platy
set state 3
tick 2
check platy
plat 8 0 0 66DD11
set state 2
set air 5
tick 1
check trigger 0
set state 4
tick 32
check trigger 0
tick 1
check trigger 1
set state 2
tick 1
check trigger 0
set state 0
tick 1
check platy
random 20

/* sim.f */
+incdir+tb
logic/mapperPkg.sv
logic/platformLfsr.sv
logic/platformPlacer.sv
logic/refreshTimer.sv
logic/spriteLayer.sv
logic/colorMapper.sv
tb/colorMapperTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = colorMapperTb
FILELIST  = sim.f
BUILD     = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD)
